/* exec_pkg.sv */
package exec_pkg;

    // datapath widths
    localparam int data_w    = 32;
    localparam int reg_idx_w = 5;
    // pc values are word addresses, byte address appends two zero bits
    localparam int addr_w    = 30;

    // fields of a decoded instruction
    localparam int imm_w     = 16;
    localparam int shamt_w   = 5;
    localparam int target_w  = 26;
    // pc bits kept by j and jal
    localparam int region_w  = addr_w - target_w;

    // jal writes its return address here
    localparam logic [reg_idx_w-1:0] link_reg = 5'd31;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_nor,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_lui
    } alu_op_e;

    // second alu operand source
    typedef enum logic [1:0] {
        y_rt,
        y_imm_sext,
        y_imm_zext
    } y_sel_e;

    typedef enum logic [2:0] {
        br_none,
        br_beq,
        br_bne,
        br_blez,
        br_bgtz,
        br_j,
        br_jal,
        br_jr
    } br_op_e;

    typedef enum logic {
        wb_alu,
        wb_link
    } wb_sel_e;

endpackage

/* operand_if.sv */
interface operand_if import exec_pkg::*; ();

    // forwarded register operands
    logic [data_w-1:0]   x;
    logic [data_w-1:0]   y;
    // raw instruction fields
    logic [imm_w-1:0]    imm;
    logic [shamt_w-1:0]  shamt;
    logic [target_w-1:0] instr_target;
    // return address, word granular
    logic [addr_w-1:0]   pc_4;

    modport src (
        output x, y, imm, shamt, pc_4, instr_target
    );

    modport alu (
        input x, y, imm, shamt
    );

    modport branch (
        input x, y, imm, pc_4, instr_target
    );

endinterface

/* operand_forward.sv */
module operand_forward import exec_pkg::*; (
    input  logic [reg_idx_w-1:0] rs_idx,
    input  logic [reg_idx_w-1:0] rt_idx,
    input  logic [data_w-1:0]    rs_data,
    input  logic [data_w-1:0]    rt_data,
    input  logic [imm_w-1:0]     imm,
    input  logic [shamt_w-1:0]   shamt,
    input  logic [target_w-1:0]  instr_target,
    input  logic [addr_w-1:0]    pc_4,
    // writeback held from the last accepted instruction
    input  logic                 fwd_en,
    input  logic [reg_idx_w-1:0] fwd_req,
    input  logic [data_w-1:0]    fwd_data,
    operand_if.src               src
);

    logic fwd_valid;
    logic hit_rs;
    logic hit_rt;

    // r0 is hardwired, never a forward source
    assign fwd_valid = fwd_en && (fwd_req != '0);

    assign hit_rs = fwd_valid && (fwd_req == rs_idx);
    assign hit_rt = fwd_valid && (fwd_req == rt_idx);

    always_comb begin
        src.x = rs_data;
        src.y = rt_data;
        if (hit_rs) begin
            src.x = fwd_data;
        end
        if (hit_rt) begin
            src.y = fwd_data;
        end
    end

    // remaining fields pass straight to both units
    assign src.imm          = imm;
    assign src.shamt        = shamt;
    assign src.instr_target = instr_target;
    assign src.pc_4         = pc_4;

endmodule

/* alu_unit.sv */
module alu_unit import exec_pkg::*; (
    input  alu_op_e           alu_op,
    input  y_sel_e            y_sel,
    operand_if.alu            alu,
    output logic [data_w-1:0] alu_res
);

    logic [data_w-1:0] imm_sext;
    logic [data_w-1:0] imm_zext;
    logic [data_w-1:0] y_op;
    logic              lt_signed;
    logic              lt_unsigned;

    assign imm_sext = {{(data_w - imm_w){alu.imm[imm_w-1]}}, alu.imm};
    assign imm_zext = {{(data_w - imm_w){1'b0}}, alu.imm};

    // second operand select
    always_comb begin
        case (y_sel)
            y_rt:       y_op = alu.y;
            y_imm_sext: y_op = imm_sext;
            y_imm_zext: y_op = imm_zext;
            default:    y_op = '0;
        endcase
    end

    assign lt_signed   = $signed(alu.x) < $signed(y_op);
    assign lt_unsigned = alu.x < y_op;

    always_comb begin
        case (alu_op)
            alu_add:  alu_res = alu.x + y_op;
            alu_sub:  alu_res = alu.x - y_op;
            alu_and:  alu_res = alu.x & y_op;
            alu_or:   alu_res = alu.x | y_op;
            alu_xor:  alu_res = alu.x ^ y_op;
            alu_nor:  alu_res = ~(alu.x | y_op);
            alu_slt:  alu_res = {{(data_w - 1){1'b0}}, lt_signed};
            alu_sltu: alu_res = {{(data_w - 1){1'b0}}, lt_unsigned};
            // shifts act on y by shamt
            alu_sll:  alu_res = y_op << alu.shamt;
            alu_srl:  alu_res = y_op >> alu.shamt;
            alu_sra:  alu_res = $signed(y_op) >>> alu.shamt;
            // immediate into the upper half
            alu_lui:  alu_res = {alu.imm, {(data_w - imm_w){1'b0}}};
            default:  alu_res = '0;
        endcase
    end

endmodule

/* branch_unit.sv */
module branch_unit import exec_pkg::*; (
    input  br_op_e            br_op,
    operand_if.branch         branch,
    output logic              taken,
    output logic [addr_w-1:0] next_pc,
    output logic              is_link
);

    logic [addr_w-1:0] br_target;
    logic [addr_w-1:0] j_target;
    logic [addr_w-1:0] jr_target;
    logic [addr_w-1:0] target;
    logic              x_zero;
    logic              x_neg;

    // branch offset counts words from pc_4
    assign br_target = branch.pc_4
                     + {{(addr_w - imm_w){branch.imm[imm_w-1]}}, branch.imm};
    assign j_target  = {branch.pc_4[addr_w-1 -: region_w], branch.instr_target};
    // jr takes a byte address from rs
    assign jr_target = branch.x[data_w-1:2];

    assign x_zero = (branch.x == '0);
    assign x_neg  = branch.x[data_w-1];

    always_comb begin
        taken  = 1'b0;
        target = br_target;
        case (br_op)
            br_beq:  taken = (branch.x == branch.y);
            br_bne:  taken = (branch.x != branch.y);
            br_blez: taken = x_neg || x_zero;
            br_bgtz: taken = !x_neg && !x_zero;
            br_j, br_jal: begin
                taken  = 1'b1;
                target = j_target;
            end
            br_jr: begin
                taken  = 1'b1;
                target = jr_target;
            end
            default: taken = 1'b0;
        endcase
    end

    // fall through when not taken
    assign next_pc = taken ? target : branch.pc_4;
    assign is_link = (br_op == br_jal);

endmodule

/* result_merge.sv */
module result_merge import exec_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 en,
    input  logic                 in_valid,
    input  wb_sel_e              wb_sel,
    input  logic                 reg_write,
    input  logic [reg_idx_w-1:0] rd_idx,
    input  logic [data_w-1:0]    alu_res,
    input  logic                 taken,
    input  logic [addr_w-1:0]    next_pc,
    input  logic                 is_link,
    input  logic [addr_w-1:0]    pred_pc,
    input  logic [addr_w-1:0]    pc_4,
    output logic                 out_valid,
    output logic                 wb_en,
    output logic [reg_idx_w-1:0] wb_req,
    output logic [data_w-1:0]    wb_data,
    output logic                 redirect,
    output logic [addr_w-1:0]    redirect_pc,
    output logic                 fwd_en,
    output logic [reg_idx_w-1:0] fwd_req,
    output logic [data_w-1:0]    fwd_data
);

    logic                 accept;
    logic [data_w-1:0]    link_data;
    logic [reg_idx_w-1:0] req_next;
    logic [data_w-1:0]    data_next;
    logic [addr_w-1:0]    resolved_pc;

    assign accept = en && in_valid;

    // return address as a byte address
    assign link_data = {pc_4, 2'b00};

    always_comb begin
        if (is_link) begin
            req_next  = link_reg;
            data_next = link_data;
        end else begin
            req_next  = rd_idx;
            data_next = (wb_sel == wb_link) ? link_data : alu_res;
        end
    end

    // resolved next address, compared with the fetch prediction
    assign resolved_pc = taken ? next_pc : pc_4;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            wb_en     <= 1'b0;
            redirect  <= 1'b0;
        end else if (en) begin
            out_valid <= in_valid;
            redirect  <= in_valid && (resolved_pc != pred_pc);
            // wb_en stays put between accepts, it is the held forward enable
            if (in_valid) begin
                wb_en <= reg_write;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            wb_req      <= req_next;
            wb_data     <= data_next;
            redirect_pc <= resolved_pc;
        end
    end

    // output registers double as the forward source
    assign fwd_en   = wb_en;
    assign fwd_req  = wb_req;
    assign fwd_data = wb_data;

endmodule

/* exec_stage.sv */
module exec_stage import exec_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 en,
    input  logic                 in_valid,
    input  alu_op_e              alu_op,
    input  y_sel_e               y_sel,
    input  br_op_e               br_op,
    input  wb_sel_e              wb_sel,
    input  logic                 reg_write,
    input  logic [reg_idx_w-1:0] rs_idx,
    input  logic [reg_idx_w-1:0] rt_idx,
    input  logic [reg_idx_w-1:0] rd_idx,
    input  logic [data_w-1:0]    rs_data,
    input  logic [data_w-1:0]    rt_data,
    input  logic [imm_w-1:0]     imm,
    input  logic [shamt_w-1:0]   shamt,
    input  logic [target_w-1:0]  instr_target,
    input  logic [addr_w-1:0]    pc_4,
    input  logic [addr_w-1:0]    pred_pc,
    output logic                 out_valid,
    output logic                 wb_en,
    output logic [reg_idx_w-1:0] wb_req,
    output logic [data_w-1:0]    wb_data,
    output logic                 redirect,
    output logic [addr_w-1:0]    redirect_pc
);

    operand_if ops ();

    logic [data_w-1:0]    alu_res;
    logic                 taken;
    logic [addr_w-1:0]    next_pc;
    logic                 is_link;
    // held writeback fed back for forwarding
    logic                 fwd_en;
    logic [reg_idx_w-1:0] fwd_req;
    logic [data_w-1:0]    fwd_data;

    operand_forward u_operand_forward (
        .rs_idx       (rs_idx),
        .rt_idx       (rt_idx),
        .rs_data      (rs_data),
        .rt_data      (rt_data),
        .imm          (imm),
        .shamt        (shamt),
        .instr_target (instr_target),
        .pc_4         (pc_4),
        .fwd_en       (fwd_en),
        .fwd_req      (fwd_req),
        .fwd_data     (fwd_data),
        .src          (ops.src)
    );

    alu_unit u_alu_unit (
        .alu_op  (alu_op),
        .y_sel   (y_sel),
        .alu     (ops.alu),
        .alu_res (alu_res)
    );

    branch_unit u_branch_unit (
        .br_op   (br_op),
        .branch  (ops.branch),
        .taken   (taken),
        .next_pc (next_pc),
        .is_link (is_link)
    );

    result_merge u_result_merge (
        .clk         (clk),
        .rst_n       (rst_n),
        .en          (en),
        .in_valid    (in_valid),
        .wb_sel      (wb_sel),
        .reg_write   (reg_write),
        .rd_idx      (rd_idx),
        .alu_res     (alu_res),
        .taken       (taken),
        .next_pc     (next_pc),
        .is_link     (is_link),
        .pred_pc     (pred_pc),
        .pc_4        (pc_4),
        .out_valid   (out_valid),
        .wb_en       (wb_en),
        .wb_req      (wb_req),
        .wb_data     (wb_data),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .fwd_en      (fwd_en),
        .fwd_req     (fwd_req),
        .fwd_data    (fwd_data)
    );

endmodule

/* tb_clock_gen.sv */
module tb_clock_gen (
    output logic clk
);
    timeunit 1ns;
    timeprecision 1ps;

    // 10 ns period
    localparam int half_period = 5;

    initial begin
        clk = 1'b0;
        forever begin
            #(half_period) clk = ~clk;
        end
    end

endmodule

/* exec_stage_checker.sv */
module exec_stage_checker import exec_pkg::*; (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 out_valid,
    input logic                 redirect,
    input logic                 wb_en,
    input logic [reg_idx_w-1:0] wb_req,
    input logic [data_w-1:0]    rs_data,
    input logic [data_w-1:0]    rt_data,
    // operands after the forward select
    input logic [data_w-1:0]    x,
    input logic [data_w-1:0]    y
);
    timeunit 1ns;
    timeprecision 1ps;

    property reset_clears_valid;
        @(posedge clk) !rst_n |=> !out_valid;
    endproperty

    property redirect_needs_valid;
        @(posedge clk) disable iff (!rst_n) redirect |-> out_valid;
    endproperty

    // r0 as the held destination never feeds an operand
    property r0_not_forwarded;
        @(posedge clk) disable iff (!rst_n)
            (wb_en && (wb_req == '0)) |-> ((x == rs_data) && (y == rt_data));
    endproperty

    a_reset_clears_valid: assert property (reset_clears_valid)
        else $error("out_valid high after a reset cycle");
    a_redirect_needs_valid: assert property (redirect_needs_valid)
        else $error("redirect raised without out_valid");
    a_r0_not_forwarded: assert property (r0_not_forwarded)
        else $error("held writeback to r0 was forwarded");

endmodule

/* tb_exec_stage.sv */
module tb_exec_stage import exec_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int reset_cycles = 16;
    localparam int n_alu        = 300;
    localparam int n_fwd        = 200;
    localparam int n_branch     = 200;
    // one accept plus up to four idle cycles per round
    localparam int n_gap_rounds = 60;
    localparam int total_cycles = reset_cycles + 4 + n_alu + n_fwd + n_branch
                                + n_gap_rounds * 5;
    localparam int watchdog_ns  = (total_cycles + 100) * 10;

    logic clk, rst_n, en, in_valid, reg_write;
    alu_op_e alu_op;
    y_sel_e  y_sel;
    br_op_e  br_op;
    wb_sel_e wb_sel;
    logic [reg_idx_w-1:0] rs_idx, rt_idx, rd_idx, wb_req;
    logic [data_w-1:0]    rs_data, rt_data, wb_data;
    logic [imm_w-1:0]     imm;
    logic [shamt_w-1:0]   shamt;
    logic [target_w-1:0]  instr_target;
    logic [addr_w-1:0]    pc_4, pred_pc, redirect_pc;
    logic out_valid, wb_en, redirect;

    // model state, mirrors the registered outputs
    logic m_out_valid, m_wb_en, m_redirect, m_have_result;
    logic [reg_idx_w-1:0] m_wb_req;
    logic [data_w-1:0]    m_wb_data;
    logic [addr_w-1:0]    m_redirect_pc;
    int test_errors, tests_passed, tests_failed;

    tb_clock_gen u_clock_gen (.clk(clk));

    exec_stage u_exec_stage (.*);

    bind exec_stage exec_stage_checker u_exec_stage_checker (
        .clk       (clk),
        .rst_n     (rst_n),
        .out_valid (out_valid),
        .redirect  (redirect),
        .wb_en     (wb_en),
        .wb_req    (wb_req),
        .rs_data   (rs_data),
        .rt_data   (rt_data),
        .x         (ops.x),
        .y         (ops.y)
    );

    function automatic logic [data_w-1:0] fwd_operand(logic [reg_idx_w-1:0] idx,
                                                      logic [data_w-1:0] data);
        if (m_wb_en && (m_wb_req != '0) && (m_wb_req == idx)) begin
            return m_wb_data;
        end
        return data;
    endfunction

    function automatic logic [data_w-1:0] model_alu(logic [data_w-1:0] x,
                                                    logic [data_w-1:0] rt);
        logic [data_w-1:0] y;
        case (y_sel)
            y_imm_sext: y = {{16{imm[15]}}, imm};
            y_imm_zext: y = {16'h0000, imm};
            default:    y = rt;
        endcase
        case (alu_op)
            alu_add:  return x + y;
            alu_sub:  return x - y;
            alu_and:  return x & y;
            alu_or:   return x | y;
            alu_xor:  return x ^ y;
            alu_nor:  return ~(x | y);
            alu_slt:  return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
            alu_sltu: return (x < y) ? 32'd1 : 32'd0;
            alu_sll:  return y << shamt;
            alu_srl:  return y >> shamt;
            alu_sra:  return $unsigned($signed(y) >>> shamt);
            alu_lui:  return {imm, 16'h0000};
            default:  return 32'd0;
        endcase
    endfunction

    // resolved next word address for the current inputs
    function automatic logic [addr_w-1:0] model_next_pc(logic [data_w-1:0] x,
                                                        logic [data_w-1:0] y);
        logic              taken;
        logic [addr_w-1:0] target;
        taken  = 1'b0;
        target = pc_4 + {{14{imm[15]}}, imm};
        case (br_op)
            br_beq:  taken = (x == y);
            br_bne:  taken = (x != y);
            br_blez: taken = ($signed(x) <= 0);
            br_bgtz: taken = ($signed(x) > 0);
            br_j, br_jal: begin
                taken  = 1'b1;
                target = {pc_4[29:26], instr_target};
            end
            br_jr: begin
                taken  = 1'b1;
                target = x[31:2];
            end
            default: taken = 1'b0;
        endcase
        return taken ? target : pc_4;
    endfunction

    function automatic logic [addr_w-1:0] predict_next();
        return model_next_pc(fwd_operand(rs_idx, rs_data), fwd_operand(rt_idx, rt_data));
    endfunction

    task automatic model_step();
        logic [data_w-1:0] x, y, res, link;
        logic [reg_idx_w-1:0] req;
        logic [addr_w-1:0] npc;
        x    = fwd_operand(rs_idx, rs_data);
        y    = fwd_operand(rt_idx, rt_data);
        npc  = model_next_pc(x, y);
        link = {pc_4, 2'b00};
        req  = (br_op == br_jal) ? link_reg : rd_idx;
        res  = (br_op == br_jal || wb_sel == wb_link) ? link : model_alu(x, y);
        if (en) begin
            m_out_valid = in_valid;
            m_redirect  = in_valid && (npc != pred_pc);
            if (in_valid) begin
                m_wb_en       = reg_write;
                m_wb_req      = req;
                m_wb_data     = res;
                m_redirect_pc = npc;
                m_have_result = 1'b1;
            end
        end
    endtask

    task automatic check_value(string name, logic [data_w-1:0] got, logic [data_w-1:0] exp);
        if (got !== exp) begin
            $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
            test_errors++;
        end
    endtask

    task automatic check_outputs();
        check_value("out_valid", 32'(out_valid), 32'(m_out_valid));
        check_value("wb_en", 32'(wb_en), 32'(m_wb_en));
        check_value("redirect", 32'(redirect), 32'(m_redirect));
        if (m_have_result) begin
            check_value("wb_req", 32'(wb_req), 32'(m_wb_req));
            check_value("wb_data", wb_data, m_wb_data);
            check_value("redirect_pc", 32'(redirect_pc), 32'(m_redirect_pc));
        end
    endtask

    // called at a falling edge with the inputs already driven
    task automatic run_cycle();
        model_step();
        @(posedge clk);
        @(negedge clk);
        check_outputs();
    endtask

    task automatic drive_random();
        en           = 1'b1;
        in_valid     = 1'b1;
        alu_op       = alu_op_e'(4'($urandom_range(0, 11)));
        y_sel        = y_sel_e'(2'($urandom_range(0, 2)));
        br_op        = br_op_e'(3'($urandom_range(0, 7)));
        wb_sel       = wb_sel_e'(1'($urandom_range(0, 1)));
        reg_write    = 1'($urandom_range(0, 1));
        rs_idx       = 5'($urandom());
        rt_idx       = 5'($urandom());
        rd_idx       = 5'($urandom());
        rs_data      = $urandom();
        rt_data      = $urandom();
        imm          = 16'($urandom());
        shamt        = 5'($urandom());
        instr_target = 26'($urandom());
        pc_4         = 30'($urandom());
        pred_pc      = pc_4;
    endtask

    task automatic finish_test(string name);
        if (test_errors == 0) begin
            $display("test %s: ok", name);
            tests_passed++;
        end else begin
            $display("test %s: %0d errors", name, test_errors);
            tests_failed++;
        end
        test_errors = 0;
    endtask

    initial begin
        #(watchdog_ns);
        $display("timeout: tests still running after %0d ns", watchdog_ns);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        logic [reg_idx_w-1:0] prev_rd;
        int gap;
        void'($urandom(32'hd121866e));
        rst_n = 1'b0;
        drive_random();
        en = 1'b0;
        in_valid = 1'b0;
        {m_out_valid, m_wb_en, m_redirect, m_have_result} = 4'b0000;
        m_wb_req = '0;
        m_wb_data = '0;
        m_redirect_pc = '0;
        test_errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // idle after reset, then a single accept
        check_outputs();
        drive_random();
        run_cycle();
        in_valid = 1'b0;
        run_cycle();
        finish_test("reset");

        for (int i = 0; i < n_alu; i++) begin
            drive_random();
            br_op  = br_none;
            wb_sel = wb_alu;
            run_cycle();
        end
        finish_test("alu");

        // each instruction reads the previous destination with stale data
        for (int i = 0; i < n_fwd; i++) begin
            prev_rd = m_wb_req;
            drive_random();
            br_op     = br_none;
            wb_sel    = wb_alu;
            y_sel     = y_rt;
            reg_write = 1'b1;
            if ($urandom_range(0, 7) == 0) begin
                rd_idx = '0;
            end
            case ($urandom_range(0, 2))
                0: rs_idx = prev_rd;
                1: rt_idx = prev_rd;
                default: begin
                    rs_idx = prev_rd;
                    rt_idx = prev_rd;
                end
            endcase
            run_cycle();
        end
        finish_test("forward");

        for (int i = 0; i < n_branch; i++) begin
            drive_random();
            if ($urandom_range(0, 1) == 1) begin
                rt_data = rs_data;
            end
            if ($urandom_range(0, 3) == 0) begin
                rs_data = '0;
            end
            if ($urandom_range(0, 1) == 1) begin
                pred_pc = predict_next();
            end else begin
                pred_pc = 30'($urandom());
            end
            run_cycle();
        end
        finish_test("branch");

        // gaps with en or in_valid low between accepts
        for (int r = 0; r < n_gap_rounds; r++) begin
            drive_random();
            // reads the writeback held across the previous gap
            rs_idx = m_wb_req;
            run_cycle();
            gap = $urandom_range(1, 4);
            repeat (gap) begin
                drive_random();
                if ($urandom_range(0, 1) == 1) begin
                    en = 1'b0;
                end else begin
                    in_valid = 1'b0;
                end
                run_cycle();
            end
        end
        finish_test("enable");

        $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* verilog.f */
exec_pkg.sv
operand_if.sv
operand_forward.sv
alu_unit.sv
branch_unit.sv
result_merge.sv
exec_stage.sv
tb_clock_gen.sv
exec_stage_checker.sv
tb_exec_stage.sv

/* run.sh */
#!/bin/sh
# build the exec_stage testbench, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --timescale 1ns/1ps --top-module tb_exec_stage \
    -f verilog.f -o sim_exec_stage \
    && ./obj_dir/sim_exec_stage | tee /dev/stderr | grep -q "^Testbench passed$" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
